/* Makefile */
VERILATOR ?= verilator
TOP       ?= uart_tb
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)

check: run
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/uart_assertions.sv */
`timescale 1ns/100ps

module uart_assertions #(
  parameter int unsigned FIFO_SZ = 8,
  localparam int unsigned CW = $clog2(FIFO_SZ+1)
)(
  input logic                      clk,
  input logic                      rst,
  input logic                      txd,
  input logic                      tcb_vld,
  input logic                      tcb_wen,
  input logic [tcb_pkg::DAT_W-1:0] tcb_rdt,
  input logic                      tx_vld,
  input logic [CW-1:0]             tx_cnt
);

  // line idles high through reset
  txd_idle_in_reset: assert property (@(posedge clk) rst |-> txd)
    else $error("txd low during reset");

  // read data only in the cycle after a read
  rdt_zero_otherwise: assert property (@(posedge clk) disable iff (rst)
    !$past(tcb_vld && !tcb_wen) |-> (tcb_rdt == '0))
    else $error("tcb_rdt nonzero without a read");

  // push into a full tx fifo must not raise the load
  no_push_past_full: assert property (@(posedge clk) disable iff (rst)
    (tx_vld && tx_cnt == CW'(FIFO_SZ)) |=> (tx_cnt <= $past(tx_cnt)))
    else $error("tx fifo load rose past its depth");

endmodule: uart_assertions

bind uart_top uart_assertions #(.FIFO_SZ(FIFO_SZ)) asrt (
  .clk(clk),
  .rst(rst),
  .txd(txd),
  .tcb_vld(tcb_vld),
  .tcb_wen(tcb_wen),
  .tcb_rdt(tcb_rdt),
  .tx_vld(tx_vld),
  .tx_cnt(tx_cnt)
);

/* bench/uart_checker.sv */
`timescale 1ns/100ps

module uart_checker (
  input  logic                      clk,
  input  logic                      rst,
  // bus as seen by the DUT
  input  logic                      tcb_vld,
  input  logic                      tcb_wen,
  input  logic [tcb_pkg::DAT_W-1:0] tcb_rdt,
  // serial output of the DUT
  input  logic                      txd,
  // clocks per bit, tracks the baud the bench wrote
  input  int                        bit_clks,
  // expected values from the bench
  input  logic                      rd_exp_vld,
  input  logic [tcb_pkg::DAT_W-1:0] rd_exp,
  input  logic                      tx_exp_vld,
  input  logic [7:0]                tx_exp,
  // progress and results
  output int                        frames_left,
  output int                        pass_cnt,
  output int                        fail_cnt
);

  logic [tcb_pkg::DAT_W-1:0] rd_q [$];
  logic [7:0]                tx_q [$];
  logic [tcb_pkg::DAT_W-1:0] rd_want;
  logic                      rd_pend;
  logic                      rst_q;
  logic                      busy;
  logic [7:0]                shift;
  logic [7:0]                want;
  int                        tick;
  int                        bit_n;

  task automatic count_pass(input string what);
    $display("[ OK ] %s", what);
    pass_cnt++;
  endtask

  task automatic flag_mismatch(input string what);
    $display("[FAIL] %0t ns: %s", $time, what);
    fail_cnt++;
  endtask

  ////////////////////////////////////////////////////////////
  // bus read response
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      rd_q.delete();
      tx_q.delete();
      rd_pend  = 1'b0;
      busy     = 1'b0;
      tick     = 0;
      pass_cnt = 0;
      fail_cnt = 0;
    end else begin
      // first cycle out of reset, line must idle high
      if (rst_q) begin
        if (txd === 1'b1) count_pass("txd high after reset");
        else flag_mismatch($sformatf("txd is %b after reset", txd));
      end
      if (rd_exp_vld) rd_q.push_back(rd_exp);
      if (tx_exp_vld) tx_q.push_back(tx_exp);
      // response belongs to the read taken last cycle
      if (rd_pend) begin
        if (tcb_rdt === rd_want) begin
          count_pass($sformatf("read data 0x%04h", tcb_rdt));
        end else begin
          flag_mismatch($sformatf("read data 0x%04h, expected 0x%04h", tcb_rdt, rd_want));
        end
      end
      rd_pend = tcb_vld && !tcb_wen;
      if (rd_pend) begin
        if (rd_q.size() == 0) begin
          $display("a bus read was seen with no expected value queued");
          fail_cnt++;
          rd_pend = 1'b0;
        end else begin
          rd_want = rd_q.pop_front();
        end
      end

      ////////////////////////////////////////////////////////
      // txd frame decode
      ////////////////////////////////////////////////////////

      // tick 0 is the first sample of the start bit
      if (!busy) begin
        if (txd == 1'b0) begin
          busy = 1'b1;
          tick = 0;
        end
      end else begin
        tick++;
      end
      if (busy && (tick % bit_clks) == (bit_clks / 2)) begin
        bit_n = tick / bit_clks;
        if (bit_n == 0 && txd) begin
          flag_mismatch("start bit on txd not low at mid bit");
          busy = 1'b0;
        end else if (bit_n >= 1 && bit_n <= 8) begin
          // lsb first
          shift = {txd, shift[7:1]};
        end else if (bit_n == 9) begin
          if (!txd) flag_mismatch($sformatf("stop bit low in txd frame 0x%02h", shift));
          if (tx_q.size() == 0) begin
            flag_mismatch($sformatf("txd frame 0x%02h not expected", shift));
          end else begin
            want = tx_q.pop_front();
            if (shift == want) count_pass($sformatf("txd frame 0x%02h", shift));
            else flag_mismatch($sformatf("txd frame 0x%02h, expected 0x%02h", shift, want));
          end
        end
      end
      // frame over once the stop bit has run out
      if (busy && tick == 10 * bit_clks - 1) busy = 1'b0;
    end
    rst_q       = rst;
    frames_left = tx_q.size() + (busy ? 1 : 0);
  end

endmodule: uart_checker

/* bench/uart_tb.sv */
`timescale 1ns/100ps

module uart_tb;

  localparam int FIFO_SZ  = 8;
  localparam int WAIT_MAX = 4000;
  localparam int OPS_MAX  = 64;
  // operation codes of the data file
  localparam logic [3:0] OP_WRITE = 4'h0;
  localparam logic [3:0] OP_READ  = 4'h1;
  localparam logic [3:0] OP_SERIAL = 4'h2;
  localparam logic [3:0] OP_FRAMES = 4'h3;
  localparam logic [3:0] OP_BURST = 4'h4;
  localparam logic [3:0] OP_END   = 4'hf;

  logic                      clk;
  logic                      rst;
  logic                      tcb_vld;
  logic                      tcb_wen;
  logic [tcb_pkg::ADR_W-1:0] tcb_adr;
  logic [tcb_pkg::DAT_W-1:0] tcb_wdt;
  logic [tcb_pkg::DAT_W-1:0] tcb_rdt;
  logic                      rxd;
  logic                      txd;
  // expectations handed to the checker
  logic                      rd_exp_vld;
  logic [tcb_pkg::DAT_W-1:0] rd_exp;
  logic                      tx_exp_vld;
  logic [7:0]                tx_exp;
  int                        frames_left;
  int                        pass_cnt;
  int                        fail_cnt;
  // op, adr, data, expected per word
  logic [39:0]               ops [OPS_MAX];
  logic [31:0]               lcg;
  int                        bit_clks;
  logic                      timed_out;

  uart_top #(.FIFO_SZ(FIFO_SZ), .DIV_W(12)) dut (
    .clk, .rst,
    .tcb_vld, .tcb_wen, .tcb_adr, .tcb_wdt, .tcb_rdt,
    .rxd, .txd
  );

  uart_checker chk (
    .clk, .rst, .tcb_vld, .tcb_wen, .tcb_rdt, .txd, .bit_clks,
    .rd_exp_vld, .rd_exp, .tx_exp_vld, .tx_exp,
    .frames_left, .pass_cnt, .fail_cnt
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////////////////////////
  // bus and line drivers
  ////////////////////////////////////////////////////////////

  task automatic bus_write(input logic [1:0] adr, input logic [15:0] dat, input logic to_tx);
    @(posedge clk);
    tcb_vld    <= 1'b1;
    tcb_wen    <= 1'b1;
    tcb_adr    <= adr;
    tcb_wdt    <= dat;
    tx_exp_vld <= to_tx;
    tx_exp     <= dat[7:0];
    @(posedge clk);
    tcb_vld    <= 1'b0;
    tx_exp_vld <= 1'b0;
  endtask

  task automatic bus_read(input logic [1:0] adr, input logic [15:0] exp);
    @(posedge clk);
    tcb_vld    <= 1'b1;
    tcb_wen    <= 1'b0;
    tcb_adr    <= adr;
    rd_exp_vld <= 1'b1;
    rd_exp     <= exp;
    @(posedge clk);
    tcb_vld    <= 1'b0;
    rd_exp_vld <= 1'b0;
  endtask

  // back to back writes, serializer takes one and the fifo fills
  task automatic write_burst(input int n);
    for (int i = 0; i < n; i++) begin
      lcg = lcg_next(lcg);
      @(posedge clk);
      tcb_vld    <= 1'b1;
      tcb_wen    <= 1'b1;
      tcb_adr    <= tcb_pkg::REG_DATA;
      tcb_wdt    <= {8'h00, lcg[23:16]};
      tx_exp_vld <= (i <= FIFO_SZ);
      tx_exp     <= lcg[23:16];
    end
    @(posedge clk);
    tcb_vld    <= 1'b0;
    tx_exp_vld <= 1'b0;
  endtask

  // start, 8 data lsb first, stop, then wait for push or error pulse
  task automatic send_frame(input logic [7:0] b, input logic bad_stop);
    int k;
    int t;
    for (k = 0; k < 10; k++) begin
      @(posedge clk);
      rxd <= (k == 0) ? 1'b0 : (k == 9) ? !bad_stop : b[k-1];
      repeat (bit_clks - 1) @(posedge clk);
    end
    @(posedge clk);
    rxd <= 1'b1;
    for (t = 0; t < WAIT_MAX; t++) begin
      @(negedge clk);
      if (dut.des_vld || dut.frame_err) break;
    end
    if (t == WAIT_MAX) begin
      $display("timeout: receiver never finished the frame carrying 0x%02h", b);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_frames;
    int t;
    for (t = 0; t < WAIT_MAX; t++) begin
      @(negedge clk);
      if (frames_left == 0) break;
    end
    if (t == WAIT_MAX) begin
      $display("timeout: %0d expected txd frames never arrived", frames_left);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_op(input logic [39:0] word);
    logic [3:0]  op;
    logic [1:0]  adr;
    logic [15:0] dat;
    logic [15:0] exp;
    op  = word[39:36];
    adr = word[33:32];
    dat = word[31:16];
    exp = word[15:0];
    case (op)
      OP_WRITE: begin
        // new bit period for the frame decoder
        if (adr == tcb_pkg::REG_BAUD) bit_clks = int'(dat) + 1;
        bus_write(adr, dat, adr == tcb_pkg::REG_DATA);
      end
      OP_READ:   bus_read(adr, exp);
      OP_SERIAL: send_frame(dat[7:0], adr[0]);
      OP_FRAMES: wait_frames();
      OP_BURST:  write_burst(int'(dat));
      default: begin
        $display("unknown operation %h in the data file", op);
        timed_out = 1'b1;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    tcb_vld    = 1'b0;
    tcb_wen    = 1'b0;
    tcb_adr    = '0;
    tcb_wdt    = '0;
    rxd        = 1'b1;
    rd_exp_vld = 1'b0;
    rd_exp     = '0;
    tx_exp_vld = 1'b0;
    tx_exp     = '0;
    lcg        = 32'h0fac995c;
    bit_clks   = 434;
    timed_out  = 1'b0;
    for (int i = 0; i < OPS_MAX; i++) ops[i] = {OP_END, 36'h0};
    $readmemh("bench/uart_testdata.txt", ops);
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < OPS_MAX && !timed_out && ops[i][39:36] != OP_END; i++) begin
      run_op(ops[i]);
    end
    // last read response lands one cycle after the request
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (frames_left != 0) $display("%0d expected txd frames are still missing", frames_left);
    $display("checks run: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && frames_left == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule: uart_tb

/* bench/uart_testdata.txt */
// op_adr_data_expect; op 0 write, 1 read and compare, 2 frame into rxd (adr 1 = low stop),
// 3 wait until all written bytes left on txd, 4 burst of data-count lcg bytes
1_1_0000_0000
1_2_0000_01b1
0_2_0003_0000
1_2_0000_0003
0_0_00a5_0000
0_0_003c_0000
0_0_0081_0000
3_0_0000_0000
2_0_0055_0000
2_0_00c3_0000
1_1_0000_0200
1_0_0000_0055
1_1_0000_0100
1_0_0000_00c3
1_0_0000_0000
4_0_000c_0000
1_1_0000_0008
3_0_0000_0000
1_1_0000_0000
2_1_0099_0000
1_1_0000_8000
0_3_0000_0000
1_1_0000_0000
2_0_005a_0000
1_1_0000_0100
1_0_0000_005a

/* logic/tcb_pkg.sv */
package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  // address selects one of four registers
  localparam int unsigned ADR_W = 2;

  // data word
  localparam int unsigned DAT_W = 16;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  typedef enum logic [ADR_W-1:0] {
    // write pushes tx byte, read pops rx byte
    REG_DATA   = 2'd0,
    // fifo loads and framing error flag
    REG_STATUS = 2'd1,
    // bit period divider
    REG_BAUD   = 2'd2,
    // write only, clears the error flag
    REG_CLEAR  = 2'd3
  } reg_adr_t;

endpackage: tcb_pkg

/* logic/uart_fifo.sv */
`timescale 1ns/100ps

module uart_fifo #(
  parameter int unsigned FIFO_SZ = 8,
  parameter int unsigned DW = 8,
  localparam int unsigned AW = $clog2(FIFO_SZ),
  localparam int unsigned CW = $clog2(FIFO_SZ+1)
)(
  input  logic          clk,
  input  logic          rst,
  // write side stream
  input  logic          sti_vld,
  input  logic [DW-1:0] sti_dat,
  output logic          sti_rdy,
  // read side stream
  output logic          sto_vld,
  output logic [DW-1:0] sto_dat,
  input  logic          sto_rdy,
  // number of stored entries
  output logic [CW-1:0] cnt
);

  // storage and pointers
  logic [DW-1:0] mem [FIFO_SZ];
  logic [AW-1:0] wr_adr;
  logic [AW-1:0] rd_adr;
  logic          sti_trn;
  logic          sto_trn;

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  assign sti_trn = sti_vld & sti_rdy;

  // wrap at depth, depth need not be a power of two
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_adr <= '0;
    end else if (sti_trn) begin
      wr_adr <= (wr_adr == AW'(FIFO_SZ-1)) ? '0 : wr_adr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (sti_trn) begin
      mem[wr_adr] <= sti_dat;
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  assign sto_trn = sto_vld & sto_rdy;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_adr <= '0;
    end else if (sto_trn) begin
      rd_adr <= (rd_adr == AW'(FIFO_SZ-1)) ? '0 : rd_adr + 1'b1;
    end
  end

  // head entry shows without a clock
  assign sto_dat = mem[rd_adr];

  ////////////////////////////////////////////////////////////
  // load counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + CW'(sti_trn) - CW'(sto_trn);
    end
  end

  // full and empty both come from the counter
  assign sti_rdy = (cnt != CW'(FIFO_SZ));
  assign sto_vld = (cnt != '0);

endmodule: uart_fifo

/* logic/uart_pkg.sv */
package uart_pkg;

  ////////////////////////////////////////////////////////////
  // frame format
  ////////////////////////////////////////////////////////////

  // data bits per frame, 8N1 only
  localparam int unsigned DATA_BITS = 8;

  ////////////////////////////////////////////////////////////
  // serializer states
  ////////////////////////////////////////////////////////////

  // transmit side
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  // receive side
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage: uart_pkg

/* logic/uart_regs.sv */
`timescale 1ns/100ps

module uart_regs #(
  parameter int unsigned FIFO_SZ = 8,
  parameter int unsigned DIV_W = 12,
  localparam int unsigned CW = $clog2(FIFO_SZ+1)
)(
  input  logic                           clk,
  input  logic                           rst,
  // host bus
  input  logic                           tcb_vld,
  input  logic                           tcb_wen,
  input  logic [tcb_pkg::ADR_W-1:0]      tcb_adr,
  input  logic [tcb_pkg::DAT_W-1:0]      tcb_wdt,
  output logic [tcb_pkg::DAT_W-1:0]      tcb_rdt,
  // tx fifo push side
  output logic                           tx_vld,
  output logic [uart_pkg::DATA_BITS-1:0] tx_dat,
  input  logic [CW-1:0]                  tx_cnt,
  // rx fifo pop side
  output logic                           rx_rdy,
  input  logic                           rx_vld,
  input  logic [uart_pkg::DATA_BITS-1:0] rx_dat,
  input  logic [CW-1:0]                  rx_cnt,
  // from the deserializer
  input  logic                           frame_err,
  // shared bit period
  output logic [DIV_W-1:0]               baud_div
);

  tcb_pkg::reg_adr_t           adr;
  logic                        wr;
  logic                        rd;
  logic                        err;
  logic [tcb_pkg::DAT_W-1:0]   status;

  ////////////////////////////////////////////////////////////
  // access decode
  ////////////////////////////////////////////////////////////

  assign adr = tcb_pkg::reg_adr_t'(tcb_adr);
  assign wr  = tcb_vld &  tcb_wen;
  assign rd  = tcb_vld & ~tcb_wen;

  // data register maps straight onto the fifo strobes
  // a full tx fifo simply refuses the push
  assign tx_vld = wr && (adr == tcb_pkg::REG_DATA);
  assign tx_dat = tcb_wdt[uart_pkg::DATA_BITS-1:0];
  // pop only happens if rx fifo is not empty
  assign rx_rdy = rd && (adr == tcb_pkg::REG_DATA);

  ////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////

  // 433 matches 115200 baud from a 50 MHz clock
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      baud_div <= DIV_W'(433);
    end else if (wr && (adr == tcb_pkg::REG_BAUD)) begin
      baud_div <= tcb_wdt[DIV_W-1:0];
    end
  end

  // sticky error, a new error beats a clear
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      err <= 1'b0;
    end else if (frame_err) begin
      err <= 1'b1;
    end else if (wr && (adr == tcb_pkg::REG_CLEAR)) begin
      err <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////

  // error in 15, rx load in 11:8, tx load in 3:0
  assign status = {err, 3'b000, 4'(rx_cnt), 4'b0000, 4'(tx_cnt)};

  // one cycle response, zero when nothing was read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tcb_rdt <= '0;
    end else if (rd) begin
      case (adr)
        tcb_pkg::REG_DATA: begin
          tcb_rdt <= rx_vld ? {{(tcb_pkg::DAT_W-uart_pkg::DATA_BITS){1'b0}}, rx_dat} : '0;
        end
        tcb_pkg::REG_STATUS: tcb_rdt <= status;
        tcb_pkg::REG_BAUD:   tcb_rdt <= {{(tcb_pkg::DAT_W-DIV_W){1'b0}}, baud_div};
        default:             tcb_rdt <= '0;
      endcase
    end else begin
      tcb_rdt <= '0;
    end
  end

endmodule: uart_regs

/* logic/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx #(
  parameter int unsigned DIV_W = 12
)(
  input  logic                           clk,
  input  logic                           rst,
  // bit period is baud_div+1 clocks
  input  logic [DIV_W-1:0]               baud_div,
  // serial line
  input  logic                           rxd,
  // byte stream into the rx fifo, no back pressure
  output logic                           dat_vld,
  output logic [uart_pkg::DATA_BITS-1:0] dat,
  // one cycle pulse on a low stop bit
  output logic                           frame_err
);

  uart_pkg::rx_state_t                    state;
  logic [1:0]                             sync;
  logic                                   rxd_s;
  logic [DIV_W-1:0]                       cnt;
  logic [$clog2(uart_pkg::DATA_BITS)-1:0] idx;
  logic                                   bit_mid;

  ////////////////////////////////////////////////////////////
  // input synchronizer
  ////////////////////////////////////////////////////////////

  // idle line is high
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], rxd};
    end
  end

  assign rxd_s = sync[1];

  // counter hits zero at the sample point
  assign bit_mid = (cnt == '0);

  ////////////////////////////////////////////////////////////
  // frame sampler
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= uart_pkg::RX_IDLE;
      cnt       <= '0;
      idx       <= '0;
      dat_vld   <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      // strobes last one cycle
      dat_vld   <= 1'b0;
      frame_err <= 1'b0;
      if (!bit_mid) begin
        cnt <= cnt - 1'b1;
      end
      case (state)
        uart_pkg::RX_IDLE: begin
          // falling edge, wait half a bit
          if (!rxd_s) begin
            state <= uart_pkg::RX_START;
            cnt   <= baud_div >> 1;
          end
        end
        uart_pkg::RX_START: begin
          if (bit_mid) begin
            // glitch, not a real start bit
            if (rxd_s) begin
              state <= uart_pkg::RX_IDLE;
            end else begin
              state <= uart_pkg::RX_DATA;
              cnt   <= baud_div;
              idx   <= '0;
            end
          end
        end
        uart_pkg::RX_DATA: begin
          if (bit_mid) begin
            cnt <= baud_div;
            idx <= idx + 1'b1;
            if (idx == 3'(uart_pkg::DATA_BITS-1)) begin
              state <= uart_pkg::RX_STOP;
            end
          end
        end
        default: begin
          // mid stop bit decides keep or drop
          if (bit_mid) begin
            state     <= uart_pkg::RX_IDLE;
            dat_vld   <= rxd_s;
            frame_err <= !rxd_s;
          end
        end
      endcase
    end
  end

  // lsb arrives first so shift in from the top
  always_ff @(posedge clk) begin
    if (state == uart_pkg::RX_DATA && bit_mid) begin
      dat <= {rxd_s, dat[uart_pkg::DATA_BITS-1:1]};
    end
  end

endmodule: uart_rx

/* logic/uart_top.sv */
`timescale 1ns/100ps

module uart_top #(
  parameter int unsigned FIFO_SZ = 8,
  parameter int unsigned DIV_W = 12,
  localparam int unsigned CW = $clog2(FIFO_SZ+1)
)(
  input  logic                      clk,
  input  logic                      rst,
  // host bus
  input  logic                      tcb_vld,
  input  logic                      tcb_wen,
  input  logic [tcb_pkg::ADR_W-1:0] tcb_adr,
  input  logic [tcb_pkg::DAT_W-1:0] tcb_wdt,
  output logic [tcb_pkg::DAT_W-1:0] tcb_rdt,
  // serial lines
  input  logic                      rxd,
  output logic                      txd
);

  // tx path from regs through the fifo to the serializer
  logic                           tx_vld;
  logic [uart_pkg::DATA_BITS-1:0] tx_dat;
  logic                           ser_vld;
  logic                           ser_rdy;
  logic [uart_pkg::DATA_BITS-1:0] ser_dat;
  logic [CW-1:0]                  tx_cnt;

  // rx path from the deserializer through the fifo to regs
  logic                           des_vld;
  logic [uart_pkg::DATA_BITS-1:0] des_dat;
  logic                           rx_vld;
  logic                           rx_rdy;
  logic [uart_pkg::DATA_BITS-1:0] rx_dat;
  logic [CW-1:0]                  rx_cnt;

  logic                           frame_err;
  logic [DIV_W-1:0]               baud_div;

  ////////////////////////////////////////////////////////////
  // register block
  ////////////////////////////////////////////////////////////

  uart_regs #(.FIFO_SZ(FIFO_SZ), .DIV_W(DIV_W)) regs (
    .clk, .rst,
    .tcb_vld, .tcb_wen, .tcb_adr, .tcb_wdt, .tcb_rdt,
    .tx_vld, .tx_dat, .tx_cnt,
    .rx_rdy, .rx_vld, .rx_dat, .rx_cnt,
    .frame_err, .baud_div
  );

  ////////////////////////////////////////////////////////////
  // transmit path
  ////////////////////////////////////////////////////////////

  // a full fifo refuses the push and the write is lost
  uart_fifo #(.FIFO_SZ(FIFO_SZ), .DW(uart_pkg::DATA_BITS)) tx_fifo (
    .clk, .rst,
    .sti_vld(tx_vld),  .sti_dat(tx_dat),  .sti_rdy(),
    .sto_vld(ser_vld), .sto_dat(ser_dat), .sto_rdy(ser_rdy),
    .cnt(tx_cnt)
  );

  uart_tx #(.DIV_W(DIV_W)) tx (
    .clk, .rst, .baud_div,
    .dat_vld(ser_vld), .dat(ser_dat), .dat_rdy(ser_rdy),
    .txd
  );

  ////////////////////////////////////////////////////////////
  // receive path
  ////////////////////////////////////////////////////////////

  uart_rx #(.DIV_W(DIV_W)) rx (
    .clk, .rst, .baud_div, .rxd,
    .dat_vld(des_vld), .dat(des_dat),
    .frame_err
  );

  // deserializer cannot wait so a full fifo loses the byte
  uart_fifo #(.FIFO_SZ(FIFO_SZ), .DW(uart_pkg::DATA_BITS)) rx_fifo (
    .clk, .rst,
    .sti_vld(des_vld), .sti_dat(des_dat), .sti_rdy(),
    .sto_vld(rx_vld),  .sto_dat(rx_dat),  .sto_rdy(rx_rdy),
    .cnt(rx_cnt)
  );

endmodule: uart_top

/* logic/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx #(
  parameter int unsigned DIV_W = 12
)(
  input  logic                          clk,
  input  logic                          rst,
  // bit period is baud_div+1 clocks
  input  logic [DIV_W-1:0]              baud_div,
  // byte stream from the tx fifo
  input  logic                          dat_vld,
  input  logic [uart_pkg::DATA_BITS-1:0] dat,
  output logic                          dat_rdy,
  // serial line
  output logic                          txd
);

  uart_pkg::tx_state_t                 state;
  logic [DIV_W-1:0]                    cnt;
  logic [$clog2(uart_pkg::DATA_BITS)-1:0] idx;
  logic [uart_pkg::DATA_BITS-1:0]      shift;
  logic                                bit_end;

  // only take a byte between frames
  assign dat_rdy = (state == uart_pkg::TX_IDLE);

  assign bit_end = (cnt == '0);

  ////////////////////////////////////////////////////////////
  // frame sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= uart_pkg::TX_IDLE;
      cnt   <= '0;
      idx   <= '0;
      txd   <= 1'b1;
    end else begin
      // count down inside every bit
      if (!bit_end) begin
        cnt <= cnt - 1'b1;
      end
      case (state)
        uart_pkg::TX_IDLE: begin
          // pop, start bit goes out next cycle
          if (dat_vld) begin
            state <= uart_pkg::TX_START;
            cnt   <= baud_div;
            txd   <= 1'b0;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_end) begin
            state <= uart_pkg::TX_DATA;
            cnt   <= baud_div;
            idx   <= '0;
            txd   <= shift[0];
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_end) begin
            cnt <= baud_div;
            if (idx == 3'(uart_pkg::DATA_BITS-1)) begin
              state <= uart_pkg::TX_STOP;
              txd   <= 1'b1;
            end else begin
              idx <= idx + 1'b1;
              txd <= shift[1];
            end
          end
        end
        default: begin
          // stop bit, line already high
          if (bit_end) begin
            state <= uart_pkg::TX_IDLE;
          end
        end
      endcase
    end
  end

  // lsb first, shift on every data bit boundary
  always_ff @(posedge clk) begin
    if (dat_rdy && dat_vld) begin
      shift <= dat;
    end else if (state == uart_pkg::TX_DATA && bit_end) begin
      shift <= shift >> 1;
    end
  end

endmodule: uart_tx

/* project.f */
logic/tcb_pkg.sv
logic/uart_pkg.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_top.sv
bench/uart_checker.sv
bench/uart_assertions.sv
bench/uart_tb.sv
